// ==== Bender.yml ====
package:
  name: ebox_seq

sources:
  - files:
      - design/eboxPkg.sv
      - design/cramStore.sv
      - design/craDispatch.sv
      - design/sbrStack.sv
      - design/ebusArb.sv
      - design/eboxSeq.sv
  - target: test
    files:
      - bench/eboxSeq_assert.sv
      - bench/eboxSeqTb.sv

// ==== bench/eboxSeqTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module eboxSeqTb;

  import eboxPkg::*;

  localparam int resetCycles   = 4;
  localparam int loadCycles    = 4 * cramDepth;
  localparam int mixedCycles   = 2000;
  localparam int deepCycles    = 300;
  localparam int unwindCycles  = 300;
  localparam int totalCycles   = resetCycles + 2 + 3 * loadCycles
                                 + mixedCycles + deepCycles + unwindCycles;
  localparam int timeoutCycles = 2 * totalCycles;

  logic       eboxClk;
  logic       arstN;
  logic       diagStrobe;
  tDiagFunc   diagFunc;
  tEbusData   ebusIn;
  logic       run;
  logic       force1777;
  tCramAdr    dramJ;
  tDispNibble nicond;
  tDispNibble sr;
  tSkipFlags  skipFlags;
  tCramAdr    cradr;
  tCtlField   ctl;
  logic       dispParity;
  tEbusData   ebusOut;
  logic       ebusDriving;
  logic       ebusConflict;

  // Reference model state
  tCramWord modelMem [cramDepth];
  tCramAdr  modelCradr;
  tCramAdr  modelDiagAdr;
  tCramAdr  modelStack [$];
  int       cycleCount = 0;

  eboxSeq UUT (.*);

  initial begin
    eboxClk = 1'b0;
    forever #4 eboxClk = ~eboxClk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stopWithFailure(string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic checkAdr(string name, tCramAdr got, tCramAdr exp);
    if (got !== exp) begin
      stopWithFailure($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkEbus(string name, tEbusData got, tEbusData exp);
    if (got !== exp) begin
      stopWithFailure($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkCtl(string name, tCtlField got, tCtlField exp);
    if (got !== exp) begin
      stopWithFailure($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkFlag(string name, logic got, logic exp);
    if (got !== exp) begin
      stopWithFailure($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  always @(posedge eboxClk) begin
    cycleCount++;
    if (cycleCount > timeoutCycles) begin
      stopWithFailure($sformatf("timeout, the run went past %0d cycles", timeoutCycles));
    end
  end

  // Bound assertions count their failures
  always @(posedge eboxClk) begin
    if (UUT.uAssert.failCount != 0) begin
      stopWithFailure("a bound assertion on the stack or EBUS failed");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Unlisted dispatch codes fall back to no dispatch
  function automatic logic [4:0] selCode(logic [4:0] disp);
    if (disp <= 5'd6) begin
      return disp;
    end
    return 5'd0;
  endfunction

  function automatic tCramAdr stackTop();
    if (modelStack.size() == 0) begin
      return '0;
    end
    return modelStack[$];
  endfunction

  function automatic tCramWord makeWord(int callPct, int retPct);
    tEbusData raw;
    tCramWord w;
    raw = tEbusData'({$urandom, $urandom});
    w = tCramWord'(raw);
    w.call = ($urandom % 100) < callPct;
    if (($urandom % 100) < retPct) begin
      w.disp = dispReturn;
    end else begin
      // Codes 7 to 9 and 20 exercise the fallback
      w.disp = 5'($urandom % 10);
      if (w.disp == dispReturn) w.disp = 5'd20;
    end
    return w;
  endfunction

  task automatic modelStep();
    tCramWord w;
    tCramAdr  contrib;
    tCramAdr  oldCradr;
    logic     doPush;
    logic     doPop;
    w = modelMem[modelCradr];
    oldCradr = modelCradr;
    case (selCode(w.disp))
      dispDiag:   contrib = modelDiagAdr;
      dispDram:   contrib = dramJ;
      dispReturn: contrib = stackTop();
      dispNicond: contrib = tCramAdr'(nicond);
      dispSr:     contrib = tCramAdr'(sr);
      dispSkip:   contrib = tCramAdr'(skipFlags[w.cond[2:0]]);
      default:    contrib = '0;
    endcase
    if (run && force1777) begin
      modelCradr = trapAdr;
      modelStack.delete();
    end else if (run) begin
      modelCradr = w.j | contrib;
      doPush = w.call;
      doPop = (selCode(w.disp) == dispReturn);
      if (doPush && doPop) begin
        if (modelStack.size() == 0) modelStack.push_back(oldCradr);
        else modelStack[$] = oldCradr;
      end else if (doPush) begin
        if (modelStack.size() == stackDepth) void'(modelStack.pop_front());
        modelStack.push_back(oldCradr);
      end else if (doPop && modelStack.size() != 0) begin
        void'(modelStack.pop_back());
      end
    end
    if (diagStrobe) begin
      case (diagFunc)
        diagLoadAdrLo: modelDiagAdr[5:0] = ebusIn[5:0];
        diagLoadAdrHi: modelDiagAdr[10:6] = ebusIn[4:0];
        diagWriteCram: modelMem[modelDiagAdr] = tCramWord'(ebusIn);
        default: ;
      endcase
    end
  endtask

  task automatic verifyOutputs();
    tCramWord w;
    tEbusData expBus;
    logic     expDrv;
    logic     parity;
    w = modelMem[modelCradr];
    parity = ^{w.call, w.disp};
    expBus = '0;
    expDrv = 1'b0;
    if (diagStrobe) begin
      expDrv = (diagFunc == diagReadCradr) || (diagFunc == diagReadStack)
               || (diagFunc == diagReadCram);
      case (diagFunc)
        diagReadCradr: expBus = tEbusData'({parity, selCode(w.disp), modelCradr});
        diagReadStack: expBus = tEbusData'({tStackPtr'(modelStack.size()), stackTop()});
        diagReadCram:  expBus = tEbusData'(modelMem[modelDiagAdr]);
        default: ;
      endcase
    end
    checkAdr("cradr", cradr, modelCradr);
    checkCtl("ctl", ctl, w.ctl);
    checkFlag("dispParity", dispParity, parity);
    checkFlag("ebusDriving", ebusDriving, expDrv);
    checkFlag("ebusConflict", ebusConflict, 1'b0);
    checkEbus("ebusOut", ebusOut, expBus);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Check mid cycle, then step the model to match the next edge
  task automatic advance();
    @(negedge eboxClk);
    verifyOutputs();
    modelStep();
    @(posedge eboxClk);
    #1;
  endtask

  task automatic setDiag(logic strobe, tDiagFunc func, tEbusData data);
    diagStrobe = strobe;
    diagFunc = func;
    ebusIn = data;
  endtask

  task automatic loadCram(int callPct, int retPct);
    tCramWord w;
    run = 1'b0;
    force1777 = 1'b0;
    for (int a = 0; a < cramDepth; a++) begin
      w = makeWord(callPct, retPct);
      setDiag(1'b1, diagLoadAdrLo, tEbusData'(a));
      advance();
      setDiag(1'b1, diagLoadAdrHi, tEbusData'(a >> diagAdrLoWidth));
      advance();
      setDiag(1'b1, diagWriteCram, tEbusData'(w));
      advance();
      setDiag(1'b1, diagReadCram, '0);
      advance();
    end
    setDiag(1'b0, '0, '0);
  endtask

  task automatic driveRandom(int forcePct);
    int pick;
    run = ($urandom % 8) != 0;
    force1777 = ($urandom % 100) < forcePct;
    dramJ = tCramAdr'($urandom);
    nicond = tDispNibble'($urandom);
    sr = tDispNibble'($urandom);
    skipFlags = tSkipFlags'($urandom);
    ebusIn = tEbusData'({$urandom, $urandom});
    pick = $urandom % 8;
    diagStrobe = (pick >= 2);
    case (pick)
      2, 7:    diagFunc = diagReadCradr;
      3:       diagFunc = diagReadStack;
      4:       diagFunc = diagReadCram;
      5:       diagFunc = diagLoadAdrLo;
      6:       diagFunc = diagLoadAdrHi;
      default: diagFunc = tDiagFunc'($urandom);
    endcase
  endtask

  task automatic runCycles(int n, int forcePct);
    for (int i = 0; i < n; i++) begin
      driveRandom(forcePct);
      advance();
    end
  endtask

  initial begin
    void'($urandom(32'h0d27c7f5));
    arstN = 1'b0;
    diagStrobe = 1'b0;
    diagFunc = '0;
    ebusIn = '0;
    run = 1'b0;
    force1777 = 1'b0;
    dramJ = '0;
    nicond = '0;
    sr = '0;
    skipFlags = '0;
    modelCradr = '0;
    modelDiagAdr = '0;
    modelStack.delete();
    repeat (resetCycles) @(posedge eboxClk);
    #1;
    arstN = 1'b1;
    checkAdr("cradr", cradr, '0);
    checkFlag("ebusDriving", ebusDriving, 1'b0);
    setDiag(1'b1, diagReadStack, '0);
    advance();
    loadCram(20, 20);
    runCycles(mixedCycles, 2);
    // Call chains deep enough to overflow the stack
    loadCram(90, 0);
    runCycles(deepCycles, 0);
    // Returns drain the stack and keep popping past empty
    loadCram(5, 80);
    runCycles(unwindCycles, 1);
    if (UUT.uAssert.failCount == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      stopWithFailure("bound assertions on the stack or EBUS failed");
    end
  end

endmodule

`default_nettype wire

// ==== bench/eboxSeq_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module eboxSeqAssert (
  input logic              eboxClk,
  input logic              arstN,
  input eboxPkg::tStackPtr stackPtr,
  input logic              diagStrobe,
  input logic              ebusDriving,
  input logic              ebusConflict
);

  import eboxPkg::*;

  // Failed assertions so far
  int failCount = 0;

  stackBound: assert property (
    @(posedge eboxClk) disable iff (!arstN)
    stackPtr <= tStackPtr'(stackDepth)
  ) else begin
    $error("stack pointer %0d is above the stack depth", stackPtr);
    failCount++;
  end

  noConflict: assert property (
    @(posedge eboxClk) disable iff (!arstN)
    !ebusConflict
  ) else begin
    $error("more than one EBUS peer is driving");
    failCount++;
  end

  // Readout only happens under a strobe
  quietBus: assert property (
    @(posedge eboxClk) disable iff (!arstN)
    !diagStrobe |-> !ebusDriving
  ) else begin
    $error("EBUS driven without a diagnostic strobe");
    failCount++;
  end

endmodule

// Stack pointer from the stack, bus status from the arbiter
bind eboxSeq eboxSeqAssert uAssert (
  .eboxClk      (eboxClk),
  .arstN        (arstN),
  .stackPtr     (uSbr.stackPtr),
  .diagStrobe   (diagStrobe),
  .ebusDriving  (uArb.ebusDriving),
  .ebusConflict (uArb.ebusConflict)
);

`default_nettype wire

// ==== design/craDispatch.sv ====
`timescale 1ns/100ps
`default_nettype none

module craDispatch (
  input  logic                eboxClk,
  input  logic                arstN,
  input  logic                run,
  input  logic                force1777,
  input  eboxPkg::tCramWord   word,
  input  eboxPkg::tCramAdr    dramJ,
  input  eboxPkg::tDispNibble nicond,
  input  eboxPkg::tDispNibble sr,
  input  eboxPkg::tSkipFlags  skipFlags,
  input  eboxPkg::tCramAdr    sbrRet,
  input  logic                diagStrobe,
  input  eboxPkg::tDiagFunc   diagFunc,
  input  eboxPkg::tEbusData   ebusIn,
  output eboxPkg::tCramAdr    cradr,
  output eboxPkg::tCramAdr    diagAdr,
  output logic                push,
  output logic                pop,
  output logic                clear,
  output logic                dispParity,
  output eboxPkg::tEbusDriver ebusDrv
);

  import eboxPkg::*;

  localparam int diagAdrHiWidth = cramAdrWidth - diagAdrLoWidth;

  tDispSel dispSel;
  tCramAdr dispMux;
  tCramAdr nextAdr;
  logic    skipBit;
  logic    readEn;

  ////////////////////////////////////////////////////////////////////////////
  // Dispatch decode and multiplexer
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (word.disp)
      dispDiag, dispDram, dispReturn, dispNicond, dispSr, dispSkip:
        dispSel = tDispSel'(word.disp);
      default:
        dispSel = dispNone;
    endcase
  end

  // Skip condition picked by the low cond bits
  assign skipBit = skipFlags[word.cond[2:0]];

  always_comb begin
    case (dispSel)
      dispDiag:   dispMux = diagAdr;
      dispDram:   dispMux = dramJ;
      dispReturn: dispMux = sbrRet;
      dispNicond: dispMux = tCramAdr'(nicond);
      dispSr:     dispMux = tCramAdr'(sr);
      dispSkip:   dispMux = tCramAdr'(skipBit);
      default:    dispMux = '0;
    endcase
  end

  // Trap entry overrides J and any dispatch
  assign nextAdr = force1777 ? trapAdr : (word.j | dispMux);

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      cradr <= '0;
    end else if (run) begin
      cradr <= nextAdr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stack control
  ////////////////////////////////////////////////////////////////////////////

  // Both push and pop together means the top gets replaced
  assign push  = run && word.call && !force1777;
  assign pop   = run && (dispSel == dispReturn) && !force1777;
  assign clear = run && force1777;

  assign dispParity = ^{word.call, word.disp};

  ////////////////////////////////////////////////////////////////////////////
  // Diagnostic address and EBUS readout
  ////////////////////////////////////////////////////////////////////////////

  // Loaded in two halves, low half first by convention
  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      diagAdr <= '0;
    end else if (diagStrobe) begin
      if (diagFunc == diagLoadAdrLo) begin
        diagAdr[diagAdrLoWidth-1:0] <= ebusIn[diagAdrLoWidth-1:0];
      end else if (diagFunc == diagLoadAdrHi) begin
        diagAdr[cramAdrWidth-1:diagAdrLoWidth] <= ebusIn[diagAdrHiWidth-1:0];
      end
    end
  end

  assign readEn = diagStrobe && (diagFunc == diagReadCradr);

  // Layout: parity in bit 16, select in 15:11, CRADR in 10:0
  always_comb begin
    ebusDrv.driving = readEn;
    if (readEn) begin
      ebusDrv.data = tEbusData'({dispParity, dispSel, cradr});
    end else begin
      ebusDrv.data = '0;
    end
  end

endmodule

`default_nettype wire

// ==== design/cramStore.sv ====
`timescale 1ns/100ps
`default_nettype none

module cramStore (
  input  logic                eboxClk,
  input  logic                arstN,
  input  logic                diagStrobe,
  input  eboxPkg::tDiagFunc   diagFunc,
  input  eboxPkg::tEbusData   ebusIn,
  input  eboxPkg::tCramAdr    diagAdr,
  input  eboxPkg::tCramAdr    cradr,
  output eboxPkg::tCramWord   word,
  output eboxPkg::tEbusDriver ebusDrv
);

  import eboxPkg::*;

  tCramWord mem [cramDepth];
  logic     writeEn;
  logic     readEn;

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  assign writeEn = diagStrobe && (diagFunc == diagWriteCram);

  // Writes are ignored while the sequencer is held in reset
  always_ff @(posedge eboxClk) begin
    if (arstN && writeEn) begin
      mem[diagAdr] <= tCramWord'(ebusIn);
    end
  end

  // Current microword, read without a clock
  assign word = mem[cradr];

  ////////////////////////////////////////////////////////////////////////////
  // EBUS readout
  ////////////////////////////////////////////////////////////////////////////

  assign readEn = diagStrobe && (diagFunc == diagReadCram);

  always_comb begin
    ebusDrv.driving = readEn;
    if (readEn) begin
      ebusDrv.data = tEbusData'(mem[diagAdr]);
    end else begin
      ebusDrv.data = '0;
    end
  end

endmodule

`default_nettype wire

// ==== design/eboxPkg.sv ====
`default_nettype none

package eboxPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int cramAdrWidth   = 11;
  localparam int ebusWidth      = 36;
  localparam int cramDepth      = 2048;
  localparam int stackDepth     = 16;
  localparam int stackPtrWidth  = 5;
  localparam int diagAdrLoWidth = 6;

  typedef logic [cramAdrWidth-1:0]  tCramAdr;
  typedef logic [ebusWidth-1:0]     tEbusData;
  typedef logic [6:0]               tDiagFunc;
  typedef logic [7:0]               tSkipFlags;
  typedef logic [3:0]               tDispNibble;
  typedef logic [12:0]              tCtlField;
  typedef logic [stackPtrWidth-1:0] tStackPtr;

  // Trap entry, historically called 1777
  localparam tCramAdr trapAdr = '1;

  ////////////////////////////////////////////////////////////////////////////
  // Microword
  ////////////////////////////////////////////////////////////////////////////

  // Same width as one EBUS word so diagnostics load it in one write
  typedef struct packed {
    tCramAdr    j;
    logic [4:0] disp;
    logic [5:0] cond;
    logic       call;
    tCtlField   ctl;
  } tCramWord;

  // Codes not listed here act as dispNone
  typedef enum logic [4:0] {
    dispNone   = 5'd0,
    dispDiag   = 5'd1,
    dispDram   = 5'd2,
    dispReturn = 5'd3,
    dispNicond = 5'd4,
    dispSr     = 5'd5,
    dispSkip   = 5'd6
  } tDispSel;

  ////////////////////////////////////////////////////////////////////////////
  // EBUS
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic     driving;
    tEbusData data;
  } tEbusDriver;

  // Peer slots on the arbiter, lowest index wins
  localparam int numPeers = 3;
  localparam int peerCra  = 0;
  localparam int peerSbr  = 1;
  localparam int peerCram = 2;

  // Diagnostic functions handled by craDispatch
  localparam tDiagFunc diagLoadAdrLo = 7'o051;
  localparam tDiagFunc diagLoadAdrHi = 7'o052;
  localparam tDiagFunc diagReadCradr = 7'o144;
  // Handled by sbrStack
  localparam tDiagFunc diagReadStack = 7'o140;
  // Handled by cramStore
  localparam tDiagFunc diagWriteCram = 7'o053;
  localparam tDiagFunc diagReadCram  = 7'o150;

endpackage

`default_nettype wire

// ==== design/eboxSeq.sv ====
`timescale 1ns/100ps
`default_nettype none

module eboxSeq (
  input  logic                eboxClk,
  input  logic                arstN,
  input  logic                diagStrobe,
  input  eboxPkg::tDiagFunc   diagFunc,
  input  eboxPkg::tEbusData   ebusIn,
  input  logic                run,
  input  logic                force1777,
  input  eboxPkg::tCramAdr    dramJ,
  input  eboxPkg::tDispNibble nicond,
  input  eboxPkg::tDispNibble sr,
  input  eboxPkg::tSkipFlags  skipFlags,
  output eboxPkg::tCramAdr    cradr,
  output eboxPkg::tCtlField   ctl,
  output logic                dispParity,
  output eboxPkg::tEbusData   ebusOut,
  output logic                ebusDriving,
  output logic                ebusConflict
);

  import eboxPkg::*;

  tCramWord                  word;
  tCramAdr                   diagAdr;
  tCramAdr                   sbrRet;
  logic                      push;
  logic                      pop;
  logic                      clear;
  tEbusDriver [numPeers-1:0] peerDrv;

  assign ctl = word.ctl;

  cramStore uCram (
    .eboxClk, .arstN, .diagStrobe, .diagFunc, .ebusIn, .diagAdr, .cradr,
    .word,
    .ebusDrv (peerDrv[peerCram])
  );

  craDispatch uCra (
    .eboxClk, .arstN, .run, .force1777, .word, .dramJ, .nicond, .sr,
    .skipFlags, .sbrRet, .diagStrobe, .diagFunc, .ebusIn,
    .cradr, .diagAdr, .push, .pop, .clear, .dispParity,
    .ebusDrv (peerDrv[peerCra])
  );

  sbrStack uSbr (
    .eboxClk, .arstN, .push, .pop, .clear, .cradr, .diagFunc, .diagStrobe,
    .sbrRet,
    .ebusDrv (peerDrv[peerSbr])
  );

  ebusArb uArb (
    .drv (peerDrv),
    .ebusOut,
    .ebusDriving,
    .ebusConflict
  );

endmodule

`default_nettype wire

// ==== design/ebusArb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ebusArb (
  input  eboxPkg::tEbusDriver [eboxPkg::numPeers-1:0] drv,
  output eboxPkg::tEbusData                          ebusOut,
  output logic                                       ebusDriving,
  output logic                                       ebusConflict
);

  import eboxPkg::*;

  logic [numPeers-1:0] drvVec;

  always_comb begin
    for (int i = 0; i < numPeers; i++) begin
      drvVec[i] = drv[i].driving;
    end
  end

  assign ebusDriving = |drvVec;

  // More than one bit set
  assign ebusConflict = |(drvVec & (drvVec - 1'b1));

  // Scan from the top so the lowest driving index is the last to land
  always_comb begin
    ebusOut = '0;
    for (int i = numPeers - 1; i >= 0; i--) begin
      if (drv[i].driving) begin
        ebusOut = drv[i].data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/sbrStack.sv ====
`timescale 1ns/100ps
`default_nettype none

module sbrStack (
  input  logic                eboxClk,
  input  logic                arstN,
  input  logic                push,
  input  logic                pop,
  input  logic                clear,
  input  eboxPkg::tCramAdr    cradr,
  input  eboxPkg::tDiagFunc   diagFunc,
  input  logic                diagStrobe,
  output eboxPkg::tCramAdr    sbrRet,
  output eboxPkg::tEbusDriver ebusDrv
);

  import eboxPkg::*;

  tCramAdr                  stack [stackDepth];
  tStackPtr                 stackPtr;
  tStackPtr                 ptrDec;
  logic [stackPtrWidth-2:0] topIdx;
  logic [stackPtrWidth-2:0] replIdx;
  logic                     empty;
  logic                     full;
  logic                     readEn;

  // Pointer counts entries, so the top sits one below it
  assign ptrDec  = stackPtr - 1'b1;
  assign topIdx  = ptrDec[stackPtrWidth-2:0];
  assign empty   = (stackPtr == '0);
  assign full    = (stackPtr == tStackPtr'(stackDepth));
  assign replIdx = empty ? '0 : topIdx;

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      stackPtr <= '0;
    end else if (clear) begin
      stackPtr <= '0;
    end else if (push && pop) begin
      if (empty) stackPtr <= tStackPtr'(1);
    end else if (push) begin
      if (!full) stackPtr <= stackPtr + 1'b1;
    end else if (pop) begin
      if (!empty) stackPtr <= ptrDec;
    end
  end

  // Entries
  always_ff @(posedge eboxClk) begin
    if (push && pop) begin
      stack[replIdx] <= cradr;
    end else if (push && full) begin
      // Oldest entry falls off the bottom
      for (int i = 0; i < stackDepth - 1; i++) begin
        stack[i] <= stack[i+1];
      end
      stack[stackDepth-1] <= cradr;
    end else if (push) begin
      stack[stackPtr[stackPtrWidth-2:0]] <= cradr;
    end
  end

  assign sbrRet = empty ? '0 : stack[topIdx];

  ////////////////////////////////////////////////////////////////////////////
  // EBUS readout
  ////////////////////////////////////////////////////////////////////////////

  assign readEn = diagStrobe && (diagFunc == diagReadStack);

  // Pointer above the top entry in the low bits
  always_comb begin
    ebusDrv.driving = readEn;
    if (readEn) begin
      ebusDrv.data = tEbusData'({stackPtr, sbrRet});
    end else begin
      ebusDrv.data = '0;
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
design/eboxPkg.sv
design/cramStore.sv
design/craDispatch.sv
design/sbrStack.sv
design/ebusArb.sv
design/eboxSeq.sv
bench/eboxSeq_assert.sv
bench/eboxSeqTb.sv
